// File: int_core_macros.svh
// Integer core constants
`ifndef INT_CORE_MACROS_SVH
`define INT_CORE_MACROS_SVH

// Datapath width and integer register count
`define XLEN 32
`define REG_COUNT 32

// RV32I major opcodes kept by the core
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI 7'b0110111

// Exception cause reported for an unsupported word
`define EXCP_ILLEGAL 4'd2

`endif

// File: int_core_pkg.sv
// Integer core types
`include "int_core_macros.svh"

package int_core_pkg;

    // Data word as seen by the ALU and the register file
    typedef logic [`XLEN-1:0] xlen_t;

    // Architectural register index
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // Raw instruction word
    typedef logic [31:0] ins_t;

    // Exception cause code
    typedef logic [3:0] excp_code_t;

    // ALU operations, PASS_B forwards operand B unchanged for LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

endpackage

// File: ins_decode.sv
// Instruction decode stage
`timescale 1ns/1ps
`include "int_core_macros.svh"

module ins_decode import int_core_pkg::*; (
    input  logic     cpu_clock_i,
    input  logic     reset_i,
    input  logic     advance_i,
    input  logic     ins_valid_i,
    input  ins_t     ins_i,
    output reg_idx_t rs1_idx_o,
    output reg_idx_t rs2_idx_o,
    input  xlen_t    rs1_data_i,
    input  xlen_t    rs2_data_i,
    output logic     dec_valid_o,
    output alu_op_t  dec_op_o,
    output xlen_t    dec_a_o,
    output xlen_t    dec_b_o,
    output reg_idx_t dec_dest_o,
    output logic     dec_wr_o,
    output logic     dec_excp_o,
    output ins_t     dec_ins_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_d;
    xlen_t      imm_i;
    xlen_t      imm_u;
    alu_op_t    op_d;
    xlen_t      a_d;
    xlen_t      b_d;
    logic       legal_d;

    assign opcode = ins_i[6:0];
    assign funct3 = ins_i[14:12];
    assign funct7 = ins_i[31:25];
    assign alt_d  = (funct7 == 7'b0100000);
    assign imm_i  = {{(`XLEN-12){ins_i[31]}}, ins_i[31:20]};
    assign imm_u  = {ins_i[31:12], 12'b0};

    // Register reads happen while the word sits on the input port
    assign rs1_idx_o = ins_i[19:15];
    assign rs2_idx_o = ins_i[24:20];

    // The alternate funct7 selects SUB over ADD and SRA over SRL
    function automatic alu_op_t f3_op(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        op_d    = f3_op(funct3, alt_d);
        a_d     = rs1_data_i;
        b_d     = rs2_data_i;
        legal_d = 1'b0;
        case (opcode)
            `OPC_OP: begin
                legal_d = (funct7 == 7'b0) ||
                          (alt_d && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            `OPC_OP_IMM: begin
                // There is no SUBI, so funct3 000 is always ADDI
                b_d  = imm_i;
                op_d = f3_op(funct3, alt_d && funct3 == 3'b101);
                if (funct3 == 3'b001) begin
                    legal_d = (funct7 == 7'b0);
                end else if (funct3 == 3'b101) begin
                    legal_d = (funct7 == 7'b0) || alt_d;
                end else begin
                    legal_d = 1'b1;
                end
            end
            `OPC_LUI: begin
                op_d    = ALU_PASS_B;
                a_d     = '0;
                b_d     = imm_u;
                legal_d = 1'b1;
            end
            default: begin
                legal_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else if (advance_i) begin
            dec_valid_o <= ins_valid_i;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (advance_i) begin
            dec_op_o   <= op_d;
            dec_a_o    <= a_d;
            dec_b_o    <= b_d;
            dec_dest_o <= ins_i[11:7];
            dec_wr_o   <= legal_d;
            dec_excp_o <= !legal_d;
            dec_ins_o  <= ins_i;
        end
    end

    // Only the kept opcodes may produce a register write
    wr_only_kept_opcode: assert property (@(posedge cpu_clock_i) disable iff (reset_i)
        dec_valid_o && dec_wr_o |-> dec_ins_o[6:0] inside {`OPC_OP, `OPC_OP_IMM, `OPC_LUI});

endmodule

// File: reg_file.sv
// Integer register file
`timescale 1ns/1ps
`include "int_core_macros.svh"

module reg_file import int_core_pkg::*; (
    input  logic     cpu_clock_i,
    input  reg_idx_t rd_idx_a_i,
    input  reg_idx_t rd_idx_b_i,
    output xlen_t    rd_data_a_o,
    output xlen_t    rd_data_b_o,
    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  xlen_t    wr_data_i
);

    // No storage behind x0
    xlen_t regs [1:`REG_COUNT-1];

    always_ff @(posedge cpu_clock_i) begin
        if (wr_en_i) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // A write in flight this cycle wins over the stored value
    function automatic xlen_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wr_en_i && wr_idx_i == idx) begin
            return wr_data_i;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd_data_a_o = read_port(rd_idx_a_i);
    end

    always_comb begin
        rd_data_b_o = read_port(rd_idx_b_i);
    end

    // Commit filters out x0 writes before they reach the port
    no_x0_write: assert property (@(posedge cpu_clock_i)
        wr_en_i |-> wr_idx_i != '0);

endmodule

// File: int_execute.sv
// Integer ALU
`timescale 1ns/1ps
`include "int_core_macros.svh"

module int_execute import int_core_pkg::*; (
    input  alu_op_t dec_op_i,
    input  xlen_t   dec_a_i,
    input  xlen_t   dec_b_i,
    output xlen_t   result_o
);

    localparam int SHW = $clog2(`XLEN);

    logic [SHW-1:0]          shamt;
    logic [`XLEN:0]          diff;
    logic                    lt_u;
    logic                    lt_s;
    logic signed [`XLEN-1:0] sra_res;

    assign shamt = dec_b_i[SHW-1:0];

    // One subtractor serves SUB and both compares, the top bit is the borrow
    assign diff = {1'b0, dec_a_i} - {1'b0, dec_b_i};
    assign lt_u = diff[`XLEN];

    // With equal signs the unsigned borrow is the answer, otherwise A's sign is
    assign lt_s = (dec_a_i[`XLEN-1] ^ dec_b_i[`XLEN-1]) ? dec_a_i[`XLEN-1] : lt_u;

    assign sra_res = $signed(dec_a_i) >>> shamt;

    always_comb begin
        case (dec_op_i)
            ALU_ADD: begin
                result_o = dec_a_i + dec_b_i;
            end
            ALU_SUB: begin
                result_o = diff[`XLEN-1:0];
            end
            ALU_SLL: begin
                result_o = dec_a_i << shamt;
            end
            ALU_SLT: begin
                result_o = {{(`XLEN-1){1'b0}}, lt_s};
            end
            ALU_SLTU: begin
                result_o = {{(`XLEN-1){1'b0}}, lt_u};
            end
            ALU_XOR: begin
                result_o = dec_a_i ^ dec_b_i;
            end
            ALU_SRL: begin
                result_o = dec_a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = sra_res;
            end
            ALU_OR: begin
                result_o = dec_a_i | dec_b_i;
            end
            ALU_AND: begin
                result_o = dec_a_i & dec_b_i;
            end
            default: begin
                result_o = dec_b_i;
            end
        endcase
    end

endmodule

// File: commit_unit.sv
// Commit and retire stage
`timescale 1ns/1ps
`include "int_core_macros.svh"

module commit_unit import int_core_pkg::*; (
    input  logic       cpu_clock_i,
    input  logic       reset_i,
    input  logic       dec_valid_i,
    input  reg_idx_t   dec_dest_i,
    input  logic       dec_wr_i,
    input  logic       dec_excp_i,
    input  ins_t       dec_ins_i,
    input  xlen_t      result_i,
    output logic       advance_o,
    output logic       wb_en_o,
    output reg_idx_t   wb_idx_o,
    output xlen_t      wb_data_o,
    output logic       retire_valid_o,
    output reg_idx_t   retire_dest_o,
    output xlen_t      retire_data_o,
    output logic       retire_excp_o,
    output excp_code_t retire_excp_code_o,
    input  logic       retire_ready_i
);

    // The whole pipeline moves when the retire slot is free or draining
    assign advance_o = !retire_valid_o || retire_ready_i;

    // Architectural write lands on the same edge the record is captured
    assign wb_en_o   = advance_o && dec_valid_i && dec_wr_i && (dec_dest_i != '0);
    assign wb_idx_o  = dec_dest_i;
    assign wb_data_o = result_i;

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            retire_valid_o <= 1'b0;
        end else if (advance_o) begin
            retire_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (advance_o) begin
            retire_dest_o      <= dec_dest_i;
            retire_data_o      <= dec_excp_i ? dec_ins_i : result_i;
            retire_excp_o      <= dec_excp_i;
            retire_excp_code_o <= dec_excp_i ? `EXCP_ILLEGAL : '0;
        end
    end

    hold_under_backpressure: assert property (@(posedge cpu_clock_i) disable iff (reset_i)
        retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_dest_o)
            && $stable(retire_data_o) && $stable(retire_excp_o)
            && $stable(retire_excp_code_o));

endmodule

// File: int_core.sv
// Integer core top level
`timescale 1ns/1ps

module int_core import int_core_pkg::*; (
    input  logic       cpu_clock_i,
    input  logic       reset_i,
    input  logic       ins_valid_i,
    input  ins_t       ins_i,
    output logic       ins_ready_o,
    output logic       retire_valid_o,
    output reg_idx_t   retire_dest_o,
    output xlen_t      retire_data_o,
    output logic       retire_excp_o,
    output excp_code_t retire_excp_code_o,
    input  logic       retire_ready_i
);

    logic     advance;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    logic     dec_valid;
    alu_op_t  dec_op;
    xlen_t    dec_a;
    xlen_t    dec_b;
    reg_idx_t dec_dest;
    logic     dec_wr;
    logic     dec_excp;
    ins_t     dec_ins;
    xlen_t    result;
    logic     wb_en;
    reg_idx_t wb_idx;
    xlen_t    wb_data;

    // The decode register accepts a word whenever the pipeline advances
    assign ins_ready_o = advance;

    ins_decode u_decode (
        .cpu_clock_i(cpu_clock_i), .reset_i(reset_i), .advance_i(advance),
        .ins_valid_i(ins_valid_i), .ins_i(ins_i),
        .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .dec_valid_o(dec_valid), .dec_op_o(dec_op), .dec_a_o(dec_a), .dec_b_o(dec_b),
        .dec_dest_o(dec_dest), .dec_wr_o(dec_wr), .dec_excp_o(dec_excp), .dec_ins_o(dec_ins)
    );

    reg_file u_regs (
        .cpu_clock_i(cpu_clock_i),
        .rd_idx_a_i(rs1_idx), .rd_idx_b_i(rs2_idx),
        .rd_data_a_o(rs1_data), .rd_data_b_o(rs2_data),
        .wr_en_i(wb_en), .wr_idx_i(wb_idx), .wr_data_i(wb_data)
    );

    int_execute u_execute (
        .dec_op_i(dec_op), .dec_a_i(dec_a), .dec_b_i(dec_b), .result_o(result)
    );

    commit_unit u_commit (
        .cpu_clock_i(cpu_clock_i), .reset_i(reset_i),
        .dec_valid_i(dec_valid), .dec_dest_i(dec_dest), .dec_wr_i(dec_wr),
        .dec_excp_i(dec_excp), .dec_ins_i(dec_ins), .result_i(result),
        .advance_o(advance), .wb_en_o(wb_en), .wb_idx_o(wb_idx), .wb_data_o(wb_data),
        .retire_valid_o(retire_valid_o), .retire_dest_o(retire_dest_o),
        .retire_data_o(retire_data_o), .retire_excp_o(retire_excp_o),
        .retire_excp_code_o(retire_excp_code_o), .retire_ready_i(retire_ready_i)
    );

endmodule

// File: tb_int_core.sv
// Integer core testbench
`timescale 1ns/1ps
`include "int_core_macros.svh"

module tb_int_core;

    localparam int LIMIT = 200;

    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] data;
        logic        excp;
        logic [31:0] edge_no;
        logic        lat;
    } rec_t;

    logic        cpu_clock = 1'b0;
    logic        reset;
    logic        ins_valid;
    logic [31:0] ins;
    logic        ins_ready;
    logic        retire_valid;
    logic [4:0]  retire_dest;
    logic [31:0] retire_data;
    logic        retire_excp;
    logic [3:0]  retire_excp_code;
    logic        retire_ready = 1'b1;

    logic [31:0] model_regs [32];
    rec_t        expected [$];
    int unsigned cycle = 0;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic        aborted = 1'b0;
    // Retire port back-pressure, the fixed latency only holds while it is off
    logic        bp_on = 1'b0;

    int_core dut (
        .cpu_clock_i(cpu_clock), .reset_i(reset), .ins_valid_i(ins_valid), .ins_i(ins),
        .ins_ready_o(ins_ready), .retire_valid_o(retire_valid), .retire_dest_o(retire_dest),
        .retire_data_o(retire_data), .retire_excp_o(retire_excp),
        .retire_excp_code_o(retire_excp_code), .retire_ready_i(retire_ready)
    );

    always #20 cpu_clock = ~cpu_clock;

    always @(posedge cpu_clock) begin
        cycle++;
        #1;
        retire_ready = bp_on ? ($urandom % 3 != 0) : 1'b1;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        value_match: assert (act === exp) else begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
                                              logic [31:0] b);
        logic signed [31:0] sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? sra : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] enc_op(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_imm(logic [11:0] imm, logic [4:0] rs1,
                                            logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] rand_legal(logic [4:0] rs1, logic [4:0] rd);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        int unsigned kind;
        f3 = 3'($urandom);
        alt = ($urandom % 2) == 1;
        imm = 12'($urandom);
        kind = $urandom % 3;
        if (kind == 0) begin
            return enc_op((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                          5'($urandom), rs1, f3, rd);
        end else if (kind == 1) begin
            // Shift immediates carry funct7 in the upper immediate bits
            if (f3 == 3'd1) begin
                imm[11:5] = 7'h00;
            end else if (f3 == 3'd5) begin
                imm[11:5] = alt ? 7'h20 : 7'h00;
            end
            return enc_imm(imm, rs1, f3, rd);
        end
        return {20'($urandom), rd, `OPC_LUI};
    endfunction

    // A store opcode or an M-extension OP word, neither is supported
    function automatic logic [31:0] rand_illegal(logic [4:0] rd);
        logic [31:0] w;
        w = $urandom;
        if ($urandom % 2 == 0) begin
            w[6:0] = 7'b0100011;
        end else begin
            w[6:0] = `OPC_OP;
            w[31:25] = 7'b0000001;
        end
        w[11:7] = rd;
        return w;
    endfunction

    task automatic predict_and_push(input logic [31:0] w);
        rec_t        r;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        legal;
        a = model_regs[w[19:15]];
        b = model_regs[w[24:20]];
        f3 = w[14:12];
        f7 = w[31:25];
        r = '0;
        legal = 1'b0;
        case (w[6:0])
            `OPC_OP: begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                r.data = alu_model(f3, f7 == 7'h20, a, b);
            end
            `OPC_OP_IMM: begin
                b = {{20{w[31]}}, w[31:20]};
                legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                        (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
                r.data = alu_model(f3, f3 == 3'd5 && f7 == 7'h20, a, b);
            end
            `OPC_LUI: begin
                legal = 1'b1;
                r.data = {w[31:12], 12'b0};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        r.dest = w[11:7];
        r.excp = !legal;
        if (!legal) begin
            r.data = w;
        end
        r.edge_no = cycle + 1;
        r.lat = !bp_on;
        if (legal && r.dest != 5'd0) begin
            model_regs[r.dest] = r.data;
        end
        expected.push_back(r);
    endtask

    task automatic check_retire();
        rec_t r;
        record_expected: assert (expected.size() != 0) else begin
            errors++;
            $display("Error: a record retired with no instruction outstanding");
        end
        if (expected.size() == 0) begin
            return;
        end
        r = expected.pop_front();
        check_value("retire_dest", 32'(r.dest), 32'(retire_dest));
        check_value("retire_data", r.data, retire_data);
        check_value("retire_excp", 32'(r.excp), 32'(retire_excp));
        if (r.excp) begin
            check_value("retire_excp_code", 32'(`EXCP_ILLEGAL), 32'(retire_excp_code));
        end
        if (r.lat) begin
            check_value("retire_edge", r.edge_no + 32'd2, cycle + 32'd1);
        end
    endtask

    // Outputs settle well before the falling edge, so all sampling happens there
    always @(negedge cpu_clock) begin
        if (cycle == 16) begin
            check_value("reset_retire_valid", 32'd0, 32'(retire_valid));
            check_value("reset_ins_ready", 32'd1, 32'(ins_ready));
        end
        if (!reset && retire_valid && retire_ready) begin
            check_retire();
        end
    end

    task automatic send_word(input logic [31:0] word);
        int waited;
        if (aborted) begin
            return;
        end
        ins_valid = 1'b1;
        ins = word;
        waited = 0;
        @(negedge cpu_clock);
        while (!ins_ready && waited < LIMIT) begin
            @(negedge cpu_clock);
            waited++;
        end
        if (ins_ready) begin
            predict_and_push(word);
        end else begin
            timeouts++;
            aborted = 1'b1;
            $display("Timeout: core held ins_ready low for %0d cycles", LIMIT);
        end
        @(posedge cpu_clock);
        #1;
        ins_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        if (aborted) begin
            return;
        end
        waited = 0;
        do begin
            @(posedge cpu_clock);
            waited++;
        end while (expected.size() != 0 && waited < LIMIT);
        #1;
        if (expected.size() != 0) begin
            timeouts++;
            aborted = 1'b1;
            $display("Timeout: retire records still outstanding after %0d cycles", LIMIT);
        end
    endtask

    task automatic set_backpressure(input logic on);
        @(negedge cpu_clock);
        bp_on = on;
        @(posedge cpu_clock);
        #1;
    endtask

    initial begin
        logic [4:0] rd;
        logic [4:0] prev;
        void'($urandom(32'h079aab98));
        reset = 1'b1;
        ins_valid = 1'b0;
        ins = '0;
        model_regs[0] = '0;
        repeat (16) @(posedge cpu_clock);
        #1;
        reset = 1'b0;

        // Register contents are unknown after reset, so every register gets a value
        for (int i = 1; i < 32; i++) begin
            send_word({20'($urandom), 5'(i), `OPC_LUI});
            send_word(enc_imm(12'($urandom), 5'(i), 3'd0, 5'(i)));
        end
        repeat (60) send_word(rand_legal(5'($urandom), 5'($urandom)));

        // Dependent chains read the register written by the previous word
        for (int c = 0; c < 4; c++) begin
            prev = 5'($urandom % 31) + 5'd1;
            repeat (8) begin
                rd = 5'($urandom % 31) + 5'd1;
                send_word(rand_legal(prev, rd));
                prev = rd;
            end
        end

        send_word(enc_imm(12'h123, 5'd5, 3'd0, 5'd0));
        send_word(enc_op(7'h00, 5'd6, 5'd5, 3'd4, 5'd0));
        send_word(enc_imm(12'd5, 5'd0, 3'd0, 5'd7));
        send_word(enc_op(7'h00, 5'd0, 5'd9, 3'd6, 5'd8));

        repeat (6) begin
            rd = 5'($urandom % 31) + 5'd1;
            send_word(rand_illegal(rd));
            send_word(enc_imm(12'd0, rd, 3'd0, 5'($urandom % 31) + 5'd1));
        end
        drain();

        set_backpressure(1'b1);
        repeat (80) begin
            if ($urandom % 4 == 0) begin
                @(posedge cpu_clock);
                #1;
            end
            if ($urandom % 8 == 0) begin
                send_word(rand_illegal(5'($urandom)));
            end else begin
                send_word(rand_legal(5'($urandom), 5'($urandom)));
            end
        end
        drain();
        set_backpressure(1'b0);

        $display("Checks %0d, errors %0d, timeouts %0d, pending %0d",
                 checks, errors, timeouts, expected.size());
        if (errors == 0 && timeouts == 0 && expected.size() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: int_core.f
+incdir+.
int_core_pkg.sv
ins_decode.sv
reg_file.sv
int_execute.sv
commit_unit.sv
int_core.sv
tb_int_core.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TB_TOP    := tb_int_core
RTL_TOP   := int_core
FILELIST  := int_core.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
